/* mem_subsys_top.f */
hw/mem_pkg.sv
hw/data_mem.sv
hw/wb_arbiter.sv
hw/block_copy_engine.sv
hw/mem_subsys_top.sv
verification/mem_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator
set -e

cd "$(dirname "$0")"

TOP=mem_subsys_tb
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
   --top-module "$TOP" \
   -f mem_subsys_top.f \
   -o "V$TOP"

./obj_dir/"V$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
   echo "simulation ended without a verdict"
   exit 1
fi
echo "simulation passed"

/* verification/mem_subsys_tb.sv */
module mem_subsys_tb import mem_pkg::*; ();

   localparam int ADDR_W     = 13;                  // 8 KiB memory
   localparam int NUM_WORDS  = 1 << (ADDR_W - 2);
   localparam int ACK_LIMIT  = 50;                  // cycles a host access may wait
   localparam int COPY_LIMIT = 4000;                // cycles a block copy may take
   localparam int SRC_BASE   = 256;                 // word index of the copy source
   localparam int DST_BASE   = 512;                 // word index of the first copy target
   localparam int HOST_BASE  = 1536;                // host scratch area, contention test

   logic              clk_i = 1'b0;
   logic              rst_n_i;
   logic              host_cyc_i;
   logic              host_stb_i;
   logic              host_we_i;
   logic [SEL_W-1:0]  host_sel_i;
   logic [ADDR_W-1:0] host_adr_i;
   logic [DATA_W-1:0] host_dat_i;
   logic              host_ack_o;
   logic [DATA_W-1:0] host_dat_o;
   logic              copy_start_i;
   logic [ADDR_W-1:0] copy_src_i;
   logic [ADDR_W-1:0] copy_dst_i;
   logic [ADDR_W-3:0] copy_len_i;
   logic              copy_busy_o;
   logic              copy_done_o;

   logic [DATA_W-1:0] shadow [0:NUM_WORDS-1];      // expected memory contents
   string             name_q [$];                  // pending read results
   logic [DATA_W-1:0] exp_q  [$];
   logic [DATA_W-1:0] act_q  [$];
   string             test_name;

   mem_subsys_top #(.ADDR_W(ADDR_W)) mem_subsys_top_inst (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .host_cyc_i(host_cyc_i), .host_stb_i(host_stb_i), .host_we_i(host_we_i),
      .host_sel_i(host_sel_i), .host_adr_i(host_adr_i), .host_dat_i(host_dat_i),
      .host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
      .copy_start_i(copy_start_i), .copy_src_i(copy_src_i), .copy_dst_i(copy_dst_i),
      .copy_len_i(copy_len_i), .copy_busy_o(copy_busy_o), .copy_done_o(copy_done_o)
   );

   always #5 clk_i = ~clk_i;                        // period 10

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // expected word after a write with byte lanes
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [SEL_W-1:0]  sel);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];         // lane taken from the new data
         end
      end
      return res;
   endfunction

   // forward word copy with pointers wrapping at the top of memory
   function automatic void shadow_copy(input logic [ADDR_W-1:0] src,
                                       input logic [ADDR_W-1:0] dst,
                                       input int                len);
      logic [ADDR_W-3:0] s;
      logic [ADDR_W-3:0] d;
      s = src[ADDR_W-1:2];
      d = dst[ADDR_W-1:2];
      for (int i = 0; i < len; i++) begin
         shadow[d] = shadow[s];
         s++;                                       // natural wrap by width
         d++;
      end
   endfunction

   task automatic check_idle_outputs();
      assert (!host_ack_o && !copy_busy_o && !copy_done_o)
         else fail_run($sformatf("outputs not low in %s", test_name));
   endtask

   task automatic wait_host_ack(output int cycles);
      int n;
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
      end while (!host_ack_o && n < ACK_LIMIT);
      assert (host_ack_o)
         else fail_run($sformatf("timeout waiting for host ack in %s", test_name));
      cycles = n;
   endtask

   // release the bus and wait one idle cycle in which ack must be low again
   task automatic end_access(input int cycles, input bit check_lat);
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
      if (check_lat) begin
         assert (cycles == 1)
            else fail_run($sformatf("ERR %s expected latency 1 actual %0d", test_name, cycles));
      end
      @(negedge clk_i);
      assert (!host_ack_o)
         else fail_run($sformatf("host ack lasted more than one cycle in %s", test_name));
   endtask

   task automatic host_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                             input logic [SEL_W-1:0] sel, input bit check_lat);
      int cycles;
      @(negedge clk_i);
      host_cyc_i = 1'b1;
      host_stb_i = 1'b1;
      host_we_i  = 1'b1;
      host_sel_i = sel;
      host_adr_i = adr;
      host_dat_i = dat;
      wait_host_ack(cycles);
      shadow[adr[ADDR_W-1:2]] = merge_bytes(shadow[adr[ADDR_W-1:2]], dat, sel);
      end_access(cycles, check_lat);
   endtask

   task automatic host_read(input logic [ADDR_W-1:0] adr, input bit check_lat);
      int cycles;
      @(negedge clk_i);
      host_cyc_i = 1'b1;
      host_stb_i = 1'b1;
      host_we_i  = 1'b0;
      host_adr_i = adr;
      wait_host_ack(cycles);
      name_q.push_back(test_name);                  // data valid while ack is high
      exp_q.push_back(shadow[adr[ADDR_W-1:2]]);
      act_q.push_back(host_dat_o);
      end_access(cycles, check_lat);
   endtask

   task automatic fill_words(input int first, input int count);
      for (int i = 0; i < count; i++) begin
         host_write(ADDR_W'((first + i) * 4), $urandom, '1, 1'b1);
      end
   endtask

   task automatic check_words(input int first, input int count);
      for (int i = 0; i < count; i++) begin
         host_read(ADDR_W'((first + i) * 4), 1'b1);
      end
   endtask

   task automatic run_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                           input int len);
      int n;
      @(negedge clk_i);
      copy_src_i   = src;
      copy_dst_i   = dst;
      copy_len_i   = (ADDR_W-2)'(len);
      copy_start_i = 1'b1;
      @(negedge clk_i);
      copy_start_i = 1'b0;                          // single cycle start
      n = 0;
      while (!copy_done_o && n < COPY_LIMIT) begin
         @(negedge clk_i);
         n++;
      end
      assert (copy_done_o)
         else fail_run($sformatf("timeout waiting for copy done in %s", test_name));
      assert (!copy_busy_o)
         else fail_run($sformatf("copy still busy at done in %s", test_name));
      shadow_copy(src, dst, len);
      @(negedge clk_i);
      assert (!copy_done_o)
         else fail_run($sformatf("copy done longer than one cycle in %s", test_name));
   endtask

   // random host reads and writes inside the scratch area
   task automatic host_traffic(input int ops);
      logic [ADDR_W-1:0] adr;
      for (int i = 0; i < ops; i++) begin
         adr = ADDR_W'((HOST_BASE + $urandom_range(0, 63)) * 4 + $urandom_range(0, 3));
         if ($urandom_range(0, 1) == 0) begin
            host_write(adr, $urandom, SEL_W'($urandom_range(1, 15)), 1'b0);
         end else begin
            host_read(adr, 1'b0);
         end
      end
   endtask

   // every captured read is compared against the shadow value taken with it
   always @(negedge clk_i) begin : compare_reads
      string             nm;
      logic [DATA_W-1:0] exp_w;
      logic [DATA_W-1:0] act_w;
      while (exp_q.size() > 0) begin
         nm    = name_q.pop_front();
         exp_w = exp_q.pop_front();
         act_w = act_q.pop_front();
         assert (act_w === exp_w)
            else fail_run($sformatf("ERR %s expected %08h actual %08h", nm, exp_w, act_w));
      end
   end

   initial begin
      logic [ADDR_W-1:0] adr;
      int                n;
      void'($urandom(16564));
      rst_n_i      = 1'b0;
      host_cyc_i   = 1'b0;
      host_stb_i   = 1'b0;
      host_we_i    = 1'b0;
      host_sel_i   = '0;
      host_adr_i   = '0;
      host_dat_i   = '0;
      copy_start_i = 1'b0;
      copy_src_i   = '0;
      copy_dst_i   = '0;
      copy_len_i   = '0;

      test_name = "reset";
      repeat (16) begin
         @(negedge clk_i);
         check_idle_outputs();
      end
      rst_n_i = 1'b1;
      repeat (4) begin
         @(negedge clk_i);
         check_idle_outputs();                      // still quiet out of reset
      end

      test_name = "byte_lanes";                     // latency is checked on every access here
      fill_words(0, 32);
      for (int i = 0; i < 64; i++) begin
         adr = ADDR_W'($urandom_range(0, 31) * 4 + $urandom_range(0, 3));   // offset ignored
         host_write(adr, $urandom, SEL_W'($urandom_range(1, 15)), 1'b1);
         host_read(adr, 1'b1);
      end

      test_name = "block_copy";
      fill_words(SRC_BASE, 64);
      fill_words(DST_BASE, 64);                     // words past len must stay as they are
      run_copy(ADDR_W'(SRC_BASE * 4), ADDR_W'(DST_BASE * 4), $urandom_range(1, 64));
      check_words(DST_BASE, 64);

      test_name = "zero_copy";
      run_copy(ADDR_W'(SRC_BASE * 4), ADDR_W'(DST_BASE * 4), 0);
      check_words(DST_BASE, 64);
      check_words(SRC_BASE, 64);

      test_name = "wrap_copy";                      // source runs over the top of memory
      fill_words(NUM_WORDS - 4, 4);
      fill_words(768, 8);
      run_copy(ADDR_W'((NUM_WORDS - 4) * 4), ADDR_W'(768 * 4), 8);
      check_words(768, 8);

      test_name = "contention";
      fill_words(HOST_BASE, 64);
      fork
         run_copy(ADDR_W'(SRC_BASE * 4), ADDR_W'(1024 * 4), 48);
         host_traffic(40);
      join
      check_words(1024, 48);
      check_words(HOST_BASE, 64);

      n = 0;
      while (exp_q.size() > 0 && n < 10) begin
         @(negedge clk_i);
         n++;
      end
      if (exp_q.size() != 0) begin
         fail_run("read results were left uncompared at the end of the run");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

/* hw/mem_subsys_top.sv */
module mem_subsys_top import mem_pkg::*; #(
   parameter int ADDR_W = 13              // 8 KiB by default
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   // host wishbone port
   input  logic              host_cyc_i,
   input  logic              host_stb_i,
   input  logic              host_we_i,
   input  logic [SEL_W-1:0]  host_sel_i,
   input  logic [ADDR_W-1:0] host_adr_i,
   input  logic [DATA_W-1:0] host_dat_i,
   output logic              host_ack_o,
   output logic [DATA_W-1:0] host_dat_o,
   // copy control
   input  logic              copy_start_i,
   input  logic [ADDR_W-1:0] copy_src_i,
   input  logic [ADDR_W-1:0] copy_dst_i,
   input  logic [ADDR_W-3:0] copy_len_i,  // in words
   output logic              copy_busy_o,
   output logic              copy_done_o
);

   // copy engine bus
   logic              copy_cyc;
   logic              copy_stb;
   logic              copy_we;
   logic [SEL_W-1:0]  copy_sel;
   logic [ADDR_W-1:0] copy_adr;
   logic [DATA_W-1:0] copy_wdat;
   logic              copy_ack;
   logic [DATA_W-1:0] copy_rdat;

   // arbiter to memory
   logic              mem_we;
   logic [SEL_W-1:0]  mem_sel;
   logic [ADDR_W-1:0] mem_adr;
   logic [DATA_W-1:0] mem_wdat;
   logic [DATA_W-1:0] mem_rdat;

   block_copy_engine #(.ADDR_W(ADDR_W)) block_copy_engine_inst (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .start_i(copy_start_i), .src_i(copy_src_i), .dst_i(copy_dst_i), .len_i(copy_len_i),
      .busy_o(copy_busy_o), .done_o(copy_done_o),
      .cyc_o(copy_cyc), .stb_o(copy_stb), .we_o(copy_we), .sel_o(copy_sel),
      .adr_o(copy_adr), .dat_o(copy_wdat), .ack_i(copy_ack), .dat_i(copy_rdat)
   );

   wb_arbiter #(.ADDR_W(ADDR_W)) wb_arbiter_inst (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .h_cyc_i(host_cyc_i), .h_stb_i(host_stb_i), .h_we_i(host_we_i), .h_sel_i(host_sel_i),
      .h_adr_i(host_adr_i), .h_dat_i(host_dat_i), .h_ack_o(host_ack_o), .h_dat_o(host_dat_o),
      .c_cyc_i(copy_cyc), .c_stb_i(copy_stb), .c_we_i(copy_we), .c_sel_i(copy_sel),
      .c_adr_i(copy_adr), .c_dat_i(copy_wdat), .c_ack_o(copy_ack), .c_dat_o(copy_rdat),
      .mem_we_o(mem_we), .mem_sel_o(mem_sel), .mem_adr_o(mem_adr),
      .mem_wdat_o(mem_wdat), .mem_rdat_i(mem_rdat)
   );

   data_mem #(.ADDR_W(ADDR_W)) data_mem_inst (
      .clk_i(clk_i), .we_i(mem_we), .sel_i(mem_sel), .addr_i(mem_adr),
      .data_i(mem_wdat), .data_o(mem_rdat)
   );

endmodule

/* hw/block_copy_engine.sv */
module block_copy_engine import mem_pkg::*; #(
   parameter int ADDR_W = 13
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   // control
   input  logic              start_i,     // sampled in idle only
   input  logic [ADDR_W-1:0] src_i,       // first source byte address
   input  logic [ADDR_W-1:0] dst_i,       // first destination byte address
   input  logic [ADDR_W-3:0] len_i,       // words to move
   output logic              busy_o,
   output logic              done_o,      // one cycle pulse at the end
   // wishbone master
   output logic              cyc_o,
   output logic              stb_o,
   output logic              we_o,
   output logic [SEL_W-1:0]  sel_o,
   output logic [ADDR_W-1:0] adr_o,
   output logic [DATA_W-1:0] dat_o,
   input  logic              ack_i,
   input  logic [DATA_W-1:0] dat_i
);

   localparam logic [ADDR_W-1:0] WORD_STEP = ADDR_W'(4);   // byte stride of one word
   localparam logic [ADDR_W-3:0] ONE_WORD  = (ADDR_W-2)'(1);

   copy_state_t          state_q;
   logic [ADDR_W-1:0]    src_q;       // next source word
   logic [ADDR_W-1:0]    dst_q;       // next destination word
   logic [ADDR_W-3:0]    cnt_q;       // words left including current
   logic [DATA_W-1:0]    word_q;      // word in flight between read and write
   logic                 gap_q;       // cyc released for one cycle between words
   logic                 active;

   assign active = (state_q == CP_READ) || (state_q == CP_WRITE);
   assign busy_o = active;
   assign done_o = (state_q == CP_DONE);

   // bus side
   // cyc stays up across the read and write of one word and drops
   // in between words so the host can get in
   assign cyc_o = active && !gap_q;
   assign stb_o = cyc_o;
   assign we_o  = (state_q == CP_WRITE);
   assign sel_o = '1;                     // whole words only
   assign adr_o = we_o ? dst_q : src_q;
   assign dat_o = word_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= CP_IDLE;
         gap_q   <= 1'b0;
         src_q   <= '0;
         dst_q   <= '0;
         cnt_q   <= '0;
      end else begin
         gap_q <= 1'b0;                   // default, set only after a write
         case (state_q)
            CP_IDLE: begin
               if (start_i) begin
                  src_q   <= {src_i[ADDR_W-1:2], 2'b00};   // word aligned
                  dst_q   <= {dst_i[ADDR_W-1:2], 2'b00};
                  cnt_q   <= len_i;
                  state_q <= (len_i == '0) ? CP_DONE : CP_READ;   // empty run skips the bus
               end
            end
            CP_READ: begin
               if (ack_i) begin
                  src_q   <= src_q + WORD_STEP;   // wraps at top of memory
                  state_q <= CP_WRITE;
               end
            end
            CP_WRITE: begin
               if (ack_i) begin
                  dst_q <= dst_q + WORD_STEP;
                  cnt_q <= cnt_q - ONE_WORD;
                  if (cnt_q == ONE_WORD) begin
                     state_q <= CP_DONE;          // last word stored
                  end else begin
                     state_q <= CP_READ;
                     gap_q   <= 1'b1;
                  end
               end
            end
            CP_DONE: state_q <= CP_IDLE;
            default: state_q <= CP_IDLE;
         endcase
      end
   end

   // holding register, loaded from the read ack
   always_ff @(posedge clk_i) begin
      if ((state_q == CP_READ) && ack_i) begin
         word_q <= dat_i;
      end
   end

   // a start during a run would be dropped, the caller must wait for done
   a_no_start_busy : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) busy_o |-> !start_i
   ) else $error("block_copy_engine: start raised while busy");

endmodule

/* hw/wb_arbiter.sv */
module wb_arbiter import mem_pkg::*; #(
   parameter int ADDR_W = 13
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   // host master
   input  logic              h_cyc_i,
   input  logic              h_stb_i,
   input  logic              h_we_i,
   input  logic [SEL_W-1:0]  h_sel_i,
   input  logic [ADDR_W-1:0] h_adr_i,
   input  logic [DATA_W-1:0] h_dat_i,
   output logic              h_ack_o,
   output logic [DATA_W-1:0] h_dat_o,
   // copy engine master
   input  logic              c_cyc_i,
   input  logic              c_stb_i,
   input  logic              c_we_i,
   input  logic [SEL_W-1:0]  c_sel_i,
   input  logic [ADDR_W-1:0] c_adr_i,
   input  logic [DATA_W-1:0] c_dat_i,
   output logic              c_ack_o,
   output logic [DATA_W-1:0] c_dat_o,
   // memory
   output logic              mem_we_o,
   output logic [SEL_W-1:0]  mem_sel_o,
   output logic [ADDR_W-1:0] mem_adr_o,
   output logic [DATA_W-1:0] mem_wdat_o,
   input  logic [DATA_W-1:0] mem_rdat_i
);

   grant_t              grant_q;     // owner in the previous cycle that routes ack
   grant_t              owner;       // owner in this cycle
   logic                held_q;      // owner had cyc up last cycle
   logic                ack_q;       // the one shared ack
   logic [DATA_W-1:0]   rdat_q;      // read word returned with ack
   logic                last_cyc;    // cyc of previous owner
   logic                other_cyc;   // cyc of the other master
   logic                pass_on;     // hand the bus over this cycle
   logic                own_cyc;
   logic                own_stb;
   logic                own_we;
   logic                issue;       // access performed at the coming edge

   // hand-over
   // an owner that kept cyc up keeps the bus, otherwise a requesting
   // peer takes it, which also settles a tie in its favour
   assign last_cyc  = (grant_q == GNT_HOST) ? h_cyc_i : c_cyc_i;
   assign other_cyc = (grant_q == GNT_HOST) ? c_cyc_i : h_cyc_i;
   assign pass_on   = other_cyc && !(held_q && last_cyc);
   assign owner     = pass_on ? ((grant_q == GNT_HOST) ? GNT_COPY : GNT_HOST) : grant_q;

   // request mux onto the memory
   always_comb begin
      if (owner == GNT_HOST) begin
         own_cyc    = h_cyc_i;
         own_stb    = h_stb_i;
         own_we     = h_we_i;
         mem_sel_o  = h_sel_i;
         mem_adr_o  = h_adr_i;
         mem_wdat_o = h_dat_i;
      end else begin
         own_cyc    = c_cyc_i;
         own_stb    = c_stb_i;
         own_we     = c_we_i;
         mem_sel_o  = c_sel_i;
         mem_adr_o  = c_adr_i;
         mem_wdat_o = c_dat_i;
      end
   end

   // no access in the ack cycle since the master may still show the old request
   assign issue    = own_cyc && own_stb && !ack_q;
   assign mem_we_o = issue && own_we;     // write lands with the ack edge

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         grant_q <= GNT_HOST;
         held_q  <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         grant_q <= owner;
         held_q  <= own_cyc;                 // continuity of the owner's cycle
         ack_q   <= issue;
      end
   end

   always_ff @(posedge clk_i) begin
      if (issue && !own_we) begin
         rdat_q <= mem_rdat_i;               // combinational read captured here
      end
   end

   // grant_q still names the master that was served
   assign h_ack_o = ack_q && (grant_q == GNT_HOST);
   assign c_ack_o = ack_q && (grant_q == GNT_COPY);
   assign h_dat_o = rdat_q;
   assign c_dat_o = rdat_q;

endmodule

/* hw/data_mem.sv */
module data_mem import mem_pkg::*; #(
   parameter int ADDR_W = 13              // byte address width
) (
   input  logic              clk_i,
   input  logic              we_i,        // write strobe, one cycle
   input  logic [SEL_W-1:0]  sel_i,       // byte lanes to write
   input  logic [ADDR_W-1:0] addr_i,      // byte address, low bits ignored
   input  logic [DATA_W-1:0] data_i,
   output logic [DATA_W-1:0] data_o       // combinational read
);

   localparam int NUM_BYTES = 1 << ADDR_W;

   // byte array, word view built from four adjacent bytes
   logic [7:0]        mem [0:NUM_BYTES-1];
   logic [ADDR_W-3:0] word_adr;            // word index

   assign word_adr = addr_i[ADDR_W-1:2];   // drop the byte offset

   // read side
   // every lane is fetched at once, no clock involved
   for (genvar lane = 0; lane < SEL_W; lane++) begin : g_rd_lane
      assign data_o[8*lane +: 8] = mem[{word_adr, 2'(lane)}];
   end

   // write side
   // lanes with a clear select bit keep their old byte
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (sel_i[b]) begin
               mem[{word_adr, 2'(b)}] <= data_i[8*b +: 8];   // lane b only
            end
         end
      end
   end

   // a write with no lane selected would be a silent no-op on the bus
   // the arbiter forwards sel straight from the master, so this
   // catches a master that starts a write cycle with an empty select
   a_write_has_lane : assert property (
      @(posedge clk_i) we_i |-> (sel_i != '0)
   ) else $error("data_mem: write with no byte lane selected");

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

   // data path of the memory and of both wishbone masters
   localparam int DATA_W = 32;             // one word per access
   localparam int SEL_W  = DATA_W / 8;     // one select bit per byte lane

   // copy engine sequence with one read then one write per word
   typedef enum logic [1:0] {
      CP_IDLE  = 2'd0,    // waiting for start
      CP_READ  = 2'd1,    // fetching a word from the source
      CP_WRITE = 2'd2,    // storing the held word at the destination
      CP_DONE  = 2'd3     // one cycle pulse state then back to idle
   } copy_state_t;

   // who owns the memory port in the arbiter
   typedef enum logic {
      GNT_HOST = 1'b0,    // external load/store port
      GNT_COPY = 1'b1     // block copy engine
   } grant_t;

   // handshake summary shared by both masters
   //   cyc and stb rise together and stay up until ack
   //   ack is a single cycle pulse registered in the arbiter
   //   read data is valid only while ack is high
   //
   // lane mapping
   //   lane 0 is data[7:0] at byte address 4n
   //   lane 3 is data[31:24] at byte address 4n+3
   //   sel picks the lanes and the low two address bits never do
   //
   // grant after reset is the host

endpackage
